//--- hw/ea_arith_pkg.sv
`default_nettype none

package ea_arith_pkg;

  localparam int data_w = 16;  // Lookahead tree is built for this width only

  typedef enum logic [2:0] {
    op_and = 3'd0,
    op_or  = 3'd1,
    op_xor = 3'd2,
    op_add = 3'd3,
    op_adc = 3'd4,
    op_sub = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic k;          // Kill the AND term
    logic l;          // XOR term on
    logic add;        // Carries reach the sum bits
    logic inv_y;
    logic cin_force;
  } core_ctl_t;

  function automatic core_ctl_t decode_op(alu_op_e op);
    core_ctl_t ctl;
    ctl = '0;
    case (op)
      op_or: begin
        ctl.l = 1'b1;
      end
      op_xor: begin
        ctl.k = 1'b1;
        ctl.l = 1'b1;
      end
      op_add, op_adc: begin
        ctl.k   = 1'b1;
        ctl.l   = 1'b1;
        ctl.add = 1'b1;
      end
      op_sub: begin
        ctl.k         = 1'b1;
        ctl.l         = 1'b1;
        ctl.add       = 1'b1;
        ctl.inv_y     = 1'b1;
        ctl.cin_force = 1'b1;  // Two's complement of y
      end
      default: begin
        ctl = '0;  // op_and and unused codes
      end
    endcase
    return ctl;
  endfunction

endpackage

`default_nettype wire

//--- hw/ea_xfer_pkg.sv
`default_nettype none

package ea_xfer_pkg;

  import ea_arith_pkg::*;

  // --------------------
  // Request stream
  // --------------------

  typedef struct packed {
    alu_op_e           op;
    logic [data_w-1:0] x;
    logic [data_w-1:0] y;
    logic              cin;  // Only looked at by op_adc
  } alu_req_t;

  // --------------------
  // Response stream
  // --------------------

  typedef struct packed {
    logic [data_w-1:0] result;
    logic              cout;
    logic              ovf;   // Signed overflow
    logic              zero;
  } alu_rsp_t;

endpackage

`default_nettype wire

//--- hw/ea_core.sv
`default_nettype none

module ea_core import ea_arith_pkg::*; (
  input  logic              k,
  input  logic              l,
  input  logic              add,
  input  logic              cin,
  input  logic [data_w-1:0] x,
  input  logic [data_w-1:0] y,
  output logic [data_w-1:0] alu,
  output logic              cout,
  output logic              ovf_n
);

  logic [15:0] g, p, al;
  logic [7:0]  g1, p1;
  logic [3:0]  g2, p2;
  logic [1:0]  g3, p3;
  logic        g4, p4;
  logic [16:0] c;  // c[i] is the carry into bit i

  assign g = x & y;
  assign p = x | y;

  // Logic term, also the half sum when k and l are both set
  assign al = ((x & y) & {16{~k}}) | ((x ^ y) & {16{l}});

  // --------------------
  // Lookahead tree
  // --------------------

  always_comb begin
    for (int j = 0; j < 8; j++) begin
      g1[j] = g[2*j+1] | (p[2*j+1] & g[2*j]);
      p1[j] = p[2*j+1] & p[2*j];
    end
    for (int j = 0; j < 4; j++) begin
      g2[j] = g1[2*j+1] | (p1[2*j+1] & g1[2*j]);
      p2[j] = p1[2*j+1] & p1[2*j];
    end
    for (int j = 0; j < 2; j++) begin
      g3[j] = g2[2*j+1] | (p2[2*j+1] & g2[2*j]);
      p3[j] = p2[2*j+1] & p2[2*j];
    end
  end

  assign g4 = g3[1] | (p3[1] & g3[0]);
  assign p4 = p3[1] & p3[0];

  // --------------------
  // Carries
  // --------------------

  assign c[0]  = cin;
  assign c[1]  = g[0] | (p[0] & cin);
  assign c[2]  = g1[0] | (p1[0] & cin);
  assign c[3]  = g[2] | (p[2] & c[2]);
  assign c[4]  = g2[0] | (p2[0] & cin);
  assign c[5]  = g[4] | (p[4] & c[4]);
  assign c[6]  = g1[2] | (p1[2] & c[4]);
  assign c[7]  = g[6] | (p[6] & c[6]);
  assign c[8]  = g3[0] | (p3[0] & cin);
  assign c[9]  = g[8] | (p[8] & c[8]);
  assign c[10] = g1[4] | (p1[4] & c[8]);
  assign c[11] = g[10] | (p[10] & c[10]);
  assign c[12] = g2[2] | (p2[2] & c[8]);
  assign c[13] = g[12] | (p[12] & c[12]);
  assign c[14] = g1[6] | (p1[6] & c[12]);
  assign c[15] = g[14] | (p[14] & c[14]);
  assign c[16] = g4 | (p4 & cin);

  // Sum bits
  assign alu  = al ^ (c[15:0] & {16{add}});
  assign cout = c[16];

  // Operand signs agree but sign of the sum differs
  assign ovf_n = !((x[15] == y[15]) && (x[15] != (c[15] ^ x[15] ^ y[15])));

endmodule

`default_nettype wire

//--- hw/ea_lane.sv
`default_nettype none

module ea_lane import ea_arith_pkg::*, ea_xfer_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  alu_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output alu_rsp_t out_rsp
);

  core_ctl_t         ctl;
  logic [data_w-1:0] y_core;
  logic [data_w-1:0] alu;
  logic              core_cin;
  logic              cout;
  logic              ovf_n;
  alu_rsp_t          rsp_d;
  logic              full;
  logic              accept;

  // --------------------
  // Decode and core
  // --------------------

  assign ctl      = decode_op(in_req.op);
  assign y_core   = ctl.inv_y ? ~in_req.y : in_req.y;
  assign core_cin = ctl.cin_force | ((in_req.op == op_adc) & in_req.cin);

  ea_core u_core (
    .k     (ctl.k),
    .l     (ctl.l),
    .add   (ctl.add),
    .cin   (core_cin),
    .x     (in_req.x),
    .y     (y_core),
    .alu   (alu),
    .cout  (cout),
    .ovf_n (ovf_n)
  );

  always_comb begin
    rsp_d.result = alu;
    rsp_d.cout   = cout & ctl.add;    // Flags only mean something for arithmetic
    rsp_d.ovf    = ~ovf_n & ctl.add;
    rsp_d.zero   = (alu == '0);
  end

  // --------------------
  // One-entry buffer
  // --------------------

  assign in_ready  = !full || out_ready;
  assign accept    = in_valid && in_ready;
  assign out_valid = full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_rsp <= rsp_d;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_rsp));

  // A blocked entry is neither overwritten nor dropped
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && full && !out_ready |-> !in_ready ##1 out_valid);

endmodule

`default_nettype wire

//--- hw/ea_dispatch.sv
`default_nettype none

module ea_dispatch import ea_xfer_pkg::*; #(
  parameter int num_lanes = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  alu_req_t             req,
  output logic [num_lanes-1:0] lane_in_valid,
  input  logic [num_lanes-1:0] lane_in_ready,
  output alu_req_t             lane_in_req
);

  localparam int ptr_w = $clog2(num_lanes);

  logic [ptr_w-1:0] ptr;
  logic             accept;

  assign lane_in_req = req;  // Shared by all lanes, valid picks the target
  assign req_ready   = lane_in_ready[ptr];
  assign accept      = req_valid && req_ready;

  always_comb begin
    lane_in_valid      = '0;
    lane_in_valid[ptr] = req_valid;
  end

  // --------------------
  // Issue pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (accept) begin
      if (ptr == ptr_w'(num_lanes - 1)) begin
        ptr <= '0;  // Wrap
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(lane_in_valid));

endmodule

`default_nettype wire

//--- hw/ea_collect.sv
`default_nettype none

module ea_collect import ea_xfer_pkg::*; #(
  parameter int num_lanes = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [num_lanes-1:0] lane_out_valid,
  output logic [num_lanes-1:0] lane_out_ready,
  input  alu_rsp_t             lane_out_rsp [num_lanes],
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output alu_rsp_t             rsp
);

  localparam int ptr_w = $clog2(num_lanes);

  logic [ptr_w-1:0] ptr;
  logic             slot_free;
  logic             take;

  // Output register empty or leaving this cycle
  assign slot_free = !rsp_valid || rsp_ready;
  assign take      = lane_out_valid[ptr] && slot_free;

  always_comb begin
    lane_out_ready      = '0;
    lane_out_ready[ptr] = slot_free;
  end

  // --------------------
  // Drain pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (take) begin
      if (ptr == ptr_w'(num_lanes - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // --------------------
  // Output stage
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (take) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp <= lane_out_rsp[ptr];
    end
  end

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

//--- hw/ea_unit_top.sv
`default_nettype none

module ea_unit_top import ea_xfer_pkg::*; #(
  parameter int num_lanes = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  output logic     req_ready,
  input  alu_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output alu_rsp_t rsp
);

  logic [num_lanes-1:0] lane_in_valid;
  logic [num_lanes-1:0] lane_in_ready;
  alu_req_t             lane_in_req;
  logic [num_lanes-1:0] lane_out_valid;
  logic [num_lanes-1:0] lane_out_ready;
  alu_rsp_t             lane_out_rsp [num_lanes];

  ea_dispatch #(.num_lanes(num_lanes)) u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready),
    .lane_in_req   (lane_in_req)
  );

  // --------------------
  // Lanes
  // --------------------

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    ea_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (lane_in_valid[i]),
      .in_ready  (lane_in_ready[i]),
      .in_req    (lane_in_req),
      .out_valid (lane_out_valid[i]),
      .out_ready (lane_out_ready[i]),
      .out_rsp   (lane_out_rsp[i])
    );
  end

  // Same rotation as the dispatcher, so order is kept
  ea_collect #(.num_lanes(num_lanes)) u_collect (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_out_valid (lane_out_valid),
    .lane_out_ready (lane_out_ready),
    .lane_out_rsp   (lane_out_rsp),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp            (rsp)
  );

endmodule

`default_nettype wire

//--- dv/ea_clkgen.sv
`default_nettype none

module ea_clkgen #(
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2 rst_n = 1'b1;  // Same offset as the stimulus
  end

endmodule

`default_nettype wire

//--- dv/ea_unit_tb.sv
`default_nettype none

module ea_unit_tb import ea_arith_pkg::*, ea_xfer_pkg::*; #(
  parameter int num_lanes = 4
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit = 200;  // Cycles per wait loop

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  logic     req_ready;
  alu_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  alu_rsp_t rsp;

  alu_rsp_t exp_q [$];
  alu_rsp_t exp_head;
  int       exp_count;
  logic     lone_accept;
  logic     stall_mode;
  logic     saw_full;

  ea_clkgen #(.reset_cycles(8)) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ea_unit_top #(.num_lanes(num_lanes)) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  task automatic abort_run(input string why);
    $display("Done: errors found");
    $fatal(1, "%s", why);
  endtask

  // --------------------
  // Reference model
  // --------------------

  function automatic alu_rsp_t expect_rsp(alu_req_t r);
    alu_rsp_t          e;
    logic [data_w-1:0] yy;
    logic              c;
    logic [data_w:0]   sum;
    e = '0;
    case (r.op)
      op_and: e.result = r.x & r.y;
      op_or:  e.result = r.x | r.y;
      op_xor: e.result = r.x ^ r.y;
      default: begin
        yy  = (r.op == op_sub) ? ~r.y : r.y;
        c   = (r.op == op_sub) || ((r.op == op_adc) && r.cin);
        sum = {1'b0, r.x} + {1'b0, yy} + {16'd0, c};
        e.result = sum[data_w-1:0];
        e.cout   = sum[data_w];
        e.ovf    = (r.x[15] == yy[15]) && (sum[15] != r.x[15]);  // Signs agree and sum flips
      end
    endcase
    e.zero = (e.result == '0);
    return e;
  endfunction

  // Push and pop 3 ns after the edge when inputs have settled
  initial begin : scoreboard
    bit pop_due;
    pop_due   = 1'b0;
    exp_count = 0;
    exp_head  = '0;
    saw_full  = 1'b0;
    forever begin
      @(posedge clk);
      #3;
      if (pop_due && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (rst_n && req_valid && req_ready) begin
        exp_q.push_back(expect_rsp(req));
      end
      if (rst_n && req_valid && !req_ready) begin
        saw_full = 1'b1;
      end
      pop_due   = rst_n && rsp_valid && rsp_ready;  // Transfer at the coming edge
      exp_count = exp_q.size();
      exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  assign lone_accept = req_valid && req_ready && (exp_count == 1);

  // --------------------
  // Checks
  // --------------------

  a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> exp_count > 0)
    else abort_run("a response arrived with no request outstanding");

  a_rsp_match: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready && exp_count > 0 |-> rsp == exp_head)
    else begin
      $display("error: %0t ns: rsp %h, expected %h", $time, $sampled(rsp), $sampled(exp_head));
      abort_run("response did not match the model");
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      $display("error: %0t ns: rsp changed while stalled", $time);
      abort_run("stalled response was not held");
    end

  // One request per cycle while responses are taken
  a_full_rate: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_ready |-> req_ready)
    else abort_run("request port was not ready while rsp_ready was high");

  // Empty unit answers exactly two edges after acceptance
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(lone_accept, 2) |-> rsp_valid && !$past(rsp_valid))
    else abort_run("first response did not appear two cycles after acceptance");

  a_reset_quiet: assert property (@(posedge clk)
    $past(!rst_n) || $past(!rst_n, 2) |-> !rsp_valid)
    else abort_run("rsp_valid was high during or just after reset");

  // --------------------
  // Stimulus
  // --------------------

  initial begin : ready_driver
    int hold;
    hold      = 0;
    rsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (!stall_mode) begin
        rsp_ready = 1'b1;
      end else if (hold == 0) begin
        rsp_ready = ~rsp_ready;
        hold      = $urandom_range(1, 12);  // Random stretch
      end else begin
        hold--;
      end
    end
  end

  function automatic alu_req_t make_req(alu_op_e op, logic [15:0] x, logic [15:0] y,
                                        logic cin);
    alu_req_t r;
    r.op  = op;
    r.x   = x;
    r.y   = y;
    r.cin = cin;
    return r;
  endfunction

  function automatic alu_req_t rand_req(int lo, int hi);
    alu_op_e op;
    op = alu_op_e'(3'($urandom_range(hi, lo)));
    return make_req(op, 16'($urandom()), 16'($urandom()), 1'($urandom()));
  endfunction

  // Called and returns 2 ns after an edge
  task automatic send_req(input alu_req_t r);
    int waited;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    #1;
    while (!req_ready && waited < wait_limit) begin
      @(posedge clk);
      #3;
      waited++;
    end
    if (!req_ready) begin
      abort_run("request was not accepted before the timeout");
    end else begin
      @(posedge clk);
      #2;
      req_valid = 1'b0;
    end
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while (exp_count > 0 && waited < wait_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_count > 0) begin
      abort_run("responses were still missing after the drain timeout");
    end
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!rst_n && waited < wait_limit);
    if (!rst_n) begin
      abort_run("reset was never released");
    end else begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin : stimulus
    void'($urandom(81164));
    req_valid  = 1'b0;
    req        = '0;
    stall_mode = 1'b0;
    wait_reset();
    send_req(make_req(op_add, 16'h0001, 16'h0002, 1'b0));
    for (int i = 0; i < 40; i++) begin
      send_req(rand_req(0, 2));  // Logic ops
    end
    for (int i = 0; i < 60; i++) begin
      send_req(rand_req(3, 5));
    end
    send_req(make_req(op_add, 16'h7fff, 16'h0001, 1'b0));
    send_req(make_req(op_add, 16'hffff, 16'h0001, 1'b0));
    send_req(make_req(op_sub, 16'h8000, 16'h0001, 1'b0));
    send_req(make_req(op_sub, 16'h5a5a, 16'h5a5a, 1'b0));
    send_req(make_req(op_adc, 16'hffff, 16'h0000, 1'b1));
    send_req(make_req(op_adc, 16'h7fff, 16'h0000, 1'b1));
    drain_all();
    send_req(make_req(op_sub, 16'h0000, 16'h0001, 1'b0));
    // Back-pressure with random stalls
    stall_mode = 1'b1;
    for (int i = 0; i < 200; i++) begin
      send_req(rand_req(0, 5));
    end
    stall_mode = 1'b0;
    drain_all();
    if (!saw_full) begin
      abort_run("back-pressure never blocked the request port");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
hw/ea_arith_pkg.sv
hw/ea_xfer_pkg.sv
hw/ea_core.sv
hw/ea_lane.sv
hw/ea_dispatch.sv
hw/ea_collect.sv
hw/ea_unit_top.sv
dv/ea_clkgen.sv
dv/ea_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ea_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ea_unit_tb -f src.f -o ea_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ea_unit_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "PASS"
exit 0
